/* cache_pkg.sv */
`default_nettype none

package cache_pkg;

    // Core side addresses count words, not bytes
    localparam int addr_width = 16;

    localparam int word_width = 32;

    localparam int words_per_line = 4;

    // Low address bits pick the word inside a line
    localparam int wsel_width = $clog2(words_per_line);

    // Memory side works on whole lines
    localparam int line_addr_width = addr_width - wsel_width;

    localparam int core_tag_width = 6;

    localparam int line_width = words_per_line * word_width;

    // Word 0 sits in the low bits of a line
    typedef logic [line_width-1:0] line_t;

    // One parked miss, kept until its line is filled
    typedef struct packed {
        logic [line_addr_width-1:0] line_addr;
        logic [wsel_width-1:0]      wsel;
        logic [core_tag_width-1:0]  tag;
    } miss_entry_t;

endpackage

`default_nettype wire

/* miss_if.sv */
`timescale 1ns/10ps
`default_nettype none

interface miss_if;

    // Controller to queue
    logic                                  add;
    cache_pkg::miss_entry_t                add_entry;
    logic [cache_pkg::line_addr_width-1:0] lookup_addr;
    logic                                  fill;
    logic [cache_pkg::line_addr_width-1:0] fill_addr;
    logic                                  pop;

    // Queue to controller
    logic                                  full;
    logic                                  stop;
    logic                                  pending;
    logic                                  head_valid;
    cache_pkg::miss_entry_t                head_entry;

    modport ctrl (
        output add, add_entry, lookup_addr, fill, fill_addr, pop,
        input  full, stop, pending, head_valid, head_entry
    );

    modport resrv (
        input  add, add_entry, lookup_addr, fill, fill_addr, pop,
        output full, stop, pending, head_valid, head_entry
    );

endinterface

`default_nettype wire

/* cache_miss_resrv.sv */
`timescale 1ns/10ps
`default_nettype none

module cache_miss_resrv #(
    parameter int mrvq_size = 8
) (
    input wire   clk,
    input wire   reset,
    miss_if.resrv mrvq
);

    localparam int ptr_width  = $clog2(mrvq_size);
    localparam int size_width = $clog2(mrvq_size + 1);
    localparam int meta_width = cache_pkg::wsel_width + cache_pkg::core_tag_width;

    logic [cache_pkg::line_addr_width-1:0] addr_table [mrvq_size];
    logic [meta_width-1:0]                 meta_table [mrvq_size];
    logic [mrvq_size-1:0]                  valid_table;
    logic [mrvq_size-1:0]                  ready_table;

    logic [ptr_width-1:0]  head_ptr;
    logic [ptr_width-1:0]  tail_ptr;
    logic [size_width-1:0] size;

    logic [mrvq_size-1:0] lookup_match;
    logic [mrvq_size-1:0] make_ready;

    logic push;
    logic pop;

    assign mrvq.full = (size == size_width'(mrvq_size));

    // Leaves room for one more core miss after the stall is seen
    assign mrvq.stop = (size >= size_width'(mrvq_size - 1));

    always_comb begin
        for (int i = 0; i < mrvq_size; i++) begin
            // Ready entries already saw their fill and own no memory request
            lookup_match[i] = valid_table[i] && !ready_table[i]
                              && (addr_table[i] == mrvq.lookup_addr);
            make_ready[i]   = mrvq.fill && valid_table[i]
                              && (addr_table[i] == mrvq.fill_addr);
        end
    end

    assign mrvq.pending = |lookup_match;

    assign mrvq.head_valid = valid_table[head_ptr] && ready_table[head_ptr];

    assign mrvq.head_entry.line_addr = addr_table[head_ptr];
    assign {mrvq.head_entry.wsel, mrvq.head_entry.tag} = meta_table[head_ptr];

    assign push = mrvq.add && !mrvq.full;
    assign pop  = mrvq.pop && mrvq.head_valid;

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_table <= '0;
            ready_table <= '0;
            head_ptr    <= '0;
            tail_ptr    <= '0;
            size        <= '0;
        end else begin
            for (int i = 0; i < mrvq_size; i++) begin
                if (make_ready[i]) begin
                    ready_table[i] <= 1'b1;
                end
            end

            if (push) begin
                valid_table[tail_ptr] <= 1'b1;
                ready_table[tail_ptr] <= 1'b0;
                tail_ptr              <= tail_ptr + 1'b1;
            end

            if (pop) begin
                valid_table[head_ptr] <= 1'b0;
                ready_table[head_ptr] <= 1'b0;
                head_ptr              <= head_ptr + 1'b1;
            end

            case ({push, pop})
                2'b10:   size <= size + 1'b1;
                2'b01:   size <= size - 1'b1;
                default: size <= size;
            endcase
        end
    end

    // Entry payload
    always_ff @(posedge clk) begin
        if (push) begin
            addr_table[tail_ptr] <= mrvq.add_entry.line_addr;
            meta_table[tail_ptr] <= {mrvq.add_entry.wsel, mrvq.add_entry.tag};
        end
    end

endmodule

`default_nettype wire

/* cache_tag_data.sv */
`timescale 1ns/10ps
`default_nettype none

module cache_tag_data #(
    parameter int num_sets = 16
) (
    input wire                                  clk,
    input wire                                  reset,

    // Lookup
    input wire [cache_pkg::line_addr_width-1:0] rd_line_addr,
    output logic                                hit,
    output cache_pkg::line_t                    rd_line,

    // Line install on fill
    input wire                                  wr_en,
    input wire [cache_pkg::line_addr_width-1:0] wr_line_addr,
    input wire cache_pkg::line_t                wr_line
);

    localparam int index_width = $clog2(num_sets);
    localparam int tag_width   = cache_pkg::line_addr_width - index_width;

    logic [tag_width-1:0] tag_table  [num_sets];
    cache_pkg::line_t     data_table [num_sets];
    logic [num_sets-1:0]  valid_table;

    logic [index_width-1:0] rd_index;
    logic [tag_width-1:0]   rd_tag;
    logic [index_width-1:0] wr_index;
    logic [tag_width-1:0]   wr_tag;

    // Low line address bits select the set
    assign rd_index = rd_line_addr[index_width-1:0];
    assign rd_tag   = rd_line_addr[cache_pkg::line_addr_width-1:index_width];
    assign wr_index = wr_line_addr[index_width-1:0];
    assign wr_tag   = wr_line_addr[cache_pkg::line_addr_width-1:index_width];

    assign hit     = valid_table[rd_index] && (tag_table[rd_index] == rd_tag);
    assign rd_line = data_table[rd_index];

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_table <= '0;
        end else if (wr_en) begin
            valid_table[wr_index] <= 1'b1;
        end
    end

    // A fill replaces whatever line held the set
    always_ff @(posedge clk) begin
        if (wr_en) begin
            tag_table[wr_index]  <= wr_tag;
            data_table[wr_index] <= wr_line;
        end
    end

endmodule

`default_nettype wire

/* cache_bank_ctrl.sv */
`timescale 1ns/10ps
`default_nettype none

module cache_bank_ctrl (
    input wire                                   clk,
    input wire                                   reset,

    // Core request
    input wire                                   core_req_valid,
    input wire [cache_pkg::addr_width-1:0]       core_req_addr,
    input wire [cache_pkg::core_tag_width-1:0]   core_req_tag,
    output logic                                 core_req_stall,

    // Core response
    output logic                                 core_rsp_valid,
    output logic [cache_pkg::word_width-1:0]     core_rsp_data,
    output logic [cache_pkg::core_tag_width-1:0] core_rsp_tag,

    // Memory request and fill
    output logic                                 mem_req_valid,
    output logic [cache_pkg::line_addr_width-1:0] mem_req_addr,
    input wire                                   mem_rsp_valid,
    input wire [cache_pkg::line_addr_width-1:0]  mem_rsp_addr,
    input wire cache_pkg::line_t                 mem_rsp_data,

    // Tag and data arrays
    output logic [cache_pkg::line_addr_width-1:0] rd_line_addr,
    input wire                                   hit,
    input wire cache_pkg::line_t                 rd_line,
    output logic                                 wr_en,
    output logic [cache_pkg::line_addr_width-1:0] wr_line_addr,
    output cache_pkg::line_t                     wr_line,

    miss_if.ctrl                                 mrvq
);

    logic do_fill;
    logic do_replay;
    logic do_core;
    logic op_hit;
    logic op_miss;

    logic [cache_pkg::line_addr_width-1:0] op_line_addr;
    logic [cache_pkg::wsel_width-1:0]      op_wsel;
    logic [cache_pkg::core_tag_width-1:0]  op_tag;

    // Fill first, then replay, then the core
    assign do_fill   = mem_rsp_valid;
    assign do_replay = !do_fill && mrvq.head_valid;
    assign do_core   = !do_fill && !mrvq.head_valid && !mrvq.stop && core_req_valid;

    assign core_req_stall = do_fill || mrvq.head_valid || mrvq.stop;

    always_comb begin
        if (do_replay) begin
            op_line_addr = mrvq.head_entry.line_addr;
            op_wsel      = mrvq.head_entry.wsel;
            op_tag       = mrvq.head_entry.tag;
        end else begin
            op_line_addr = core_req_addr[cache_pkg::addr_width-1:cache_pkg::wsel_width];
            op_wsel      = core_req_addr[cache_pkg::wsel_width-1:0];
            op_tag       = core_req_tag;
        end
    end

    assign rd_line_addr = op_line_addr;

    assign op_hit  = (do_replay || do_core) && hit;
    assign op_miss = (do_replay || do_core) && !hit;

    // A replay that misses goes back to the tail
    assign mrvq.add                 = op_miss;
    assign mrvq.add_entry.line_addr = op_line_addr;
    assign mrvq.add_entry.wsel      = op_wsel;
    assign mrvq.add_entry.tag       = op_tag;
    assign mrvq.lookup_addr         = op_line_addr;
    assign mrvq.pop                 = do_replay;

    assign mrvq.fill      = do_fill;
    assign mrvq.fill_addr = mem_rsp_addr;

    assign wr_en        = do_fill;
    assign wr_line_addr = mem_rsp_addr;
    assign wr_line      = mem_rsp_data;

    always_ff @(posedge clk) begin
        if (reset) begin
            core_rsp_valid <= 1'b0;
            mem_req_valid  <= 1'b0;
        end else begin
            core_rsp_valid <= op_hit;
            // Another miss already asked for this line
            mem_req_valid  <= op_miss && !mrvq.pending;
        end
    end

    always_ff @(posedge clk) begin
        if (op_hit) begin
            core_rsp_data <= rd_line[op_wsel*cache_pkg::word_width +: cache_pkg::word_width];
            core_rsp_tag  <= op_tag;
        end
        if (op_miss) begin
            mem_req_addr <= op_line_addr;
        end
    end

endmodule

`default_nettype wire

/* cache_bank.sv */
`timescale 1ns/10ps
`default_nettype none

module cache_bank #(
    parameter int mrvq_size = 8,
    parameter int num_sets  = 16
) (
    input wire                                    clk,
    input wire                                    reset,

    input wire                                    core_req_valid,
    input wire [cache_pkg::addr_width-1:0]        core_req_addr,
    input wire [cache_pkg::core_tag_width-1:0]    core_req_tag,
    output logic                                  core_req_stall,
    output logic                                  core_rsp_valid,
    output logic [cache_pkg::word_width-1:0]      core_rsp_data,
    output logic [cache_pkg::core_tag_width-1:0]  core_rsp_tag,

    output logic                                  mem_req_valid,
    output logic [cache_pkg::line_addr_width-1:0] mem_req_addr,
    input wire                                    mem_rsp_valid,
    input wire [cache_pkg::line_addr_width-1:0]   mem_rsp_addr,
    input wire cache_pkg::line_t                  mem_rsp_data
);

    logic [cache_pkg::line_addr_width-1:0] rd_line_addr;
    logic                                  hit;
    cache_pkg::line_t                      rd_line;
    logic                                  wr_en;
    logic [cache_pkg::line_addr_width-1:0] wr_line_addr;
    cache_pkg::line_t                      wr_line;

    miss_if mrvq ();

    cache_bank_ctrl ctrl (
        .clk            (clk),
        .reset          (reset),
        .core_req_valid (core_req_valid),
        .core_req_addr  (core_req_addr),
        .core_req_tag   (core_req_tag),
        .core_req_stall (core_req_stall),
        .core_rsp_valid (core_rsp_valid),
        .core_rsp_data  (core_rsp_data),
        .core_rsp_tag   (core_rsp_tag),
        .mem_req_valid  (mem_req_valid),
        .mem_req_addr   (mem_req_addr),
        .mem_rsp_valid  (mem_rsp_valid),
        .mem_rsp_addr   (mem_rsp_addr),
        .mem_rsp_data   (mem_rsp_data),
        .rd_line_addr   (rd_line_addr),
        .hit            (hit),
        .rd_line        (rd_line),
        .wr_en          (wr_en),
        .wr_line_addr   (wr_line_addr),
        .wr_line        (wr_line),
        .mrvq           (mrvq.ctrl)
    );

    cache_tag_data #(
        .num_sets (num_sets)
    ) tag_data (
        .clk          (clk),
        .reset        (reset),
        .rd_line_addr (rd_line_addr),
        .hit          (hit),
        .rd_line      (rd_line),
        .wr_en        (wr_en),
        .wr_line_addr (wr_line_addr),
        .wr_line      (wr_line)
    );

    cache_miss_resrv #(
        .mrvq_size (mrvq_size)
    ) miss_resrv (
        .clk   (clk),
        .reset (reset),
        .mrvq  (mrvq.resrv)
    );

endmodule

`default_nettype wire

/* cache_bank_checker.sv */
`timescale 1ns/10ps
`default_nettype none

module cache_bank_checker (
    input wire clk,
    input wire reset,
    input wire mem_req_valid,
    input wire core_rsp_valid,
    input wire add,
    input wire full,
    input wire pop,
    input wire head_valid
);

    // Registered outputs come out of reset cleared
    quiet_after_reset: assert property (
        @(posedge clk) reset |=> !mem_req_valid && !core_rsp_valid
    ) else $error("memory request or core response high right after reset");

    no_push_when_full: assert property (
        @(posedge clk) disable iff (reset) add |-> !full
    ) else $error("miss entry pushed while the queue is full");

    // A ready head entry stays at the head until it is replayed
    head_held_until_pop: assert property (
        @(posedge clk) disable iff (reset) head_valid && !pop |=> head_valid
    ) else $error("ready head entry dropped before it was popped");

endmodule

bind cache_bank_ctrl cache_bank_checker bank_checks (
    .clk            (clk),
    .reset          (reset),
    .mem_req_valid  (mem_req_valid),
    .core_rsp_valid (core_rsp_valid),
    .add            (mrvq.add),
    .full           (mrvq.full),
    .pop            (mrvq.pop),
    .head_valid     (mrvq.head_valid)
);

`default_nettype wire

/* cache_bank_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module cache_bank_tb;

    localparam int mrvq_size  = 8;
    localparam int num_sets   = 16;
    localparam int num_tags   = 1 << cache_pkg::core_tag_width;
    localparam int wait_limit = 5000;

    logic                                  clk            = 1'b0;
    logic                                  reset          = 1'b1;
    logic                                  core_req_valid = 1'b0;
    logic [cache_pkg::addr_width-1:0]      core_req_addr  = '0;
    logic [cache_pkg::core_tag_width-1:0]  core_req_tag   = '0;
    logic                                  core_req_stall;
    logic                                  core_rsp_valid;
    logic [cache_pkg::word_width-1:0]      core_rsp_data;
    logic [cache_pkg::core_tag_width-1:0]  core_rsp_tag;
    logic                                  mem_req_valid;
    logic [cache_pkg::line_addr_width-1:0] mem_req_addr;
    logic                                  mem_rsp_valid  = 1'b0;
    logic [cache_pkg::line_addr_width-1:0] mem_rsp_addr   = '0;
    cache_pkg::line_t                      mem_rsp_data   = '0;

    // Each scoreboard array has one writing process
    int                                   issue_cnt [num_tags] = '{default: 0};
    int                                   done_cnt  [num_tags] = '{default: 0};
    int                                   take_cycle [num_tags];
    logic [cache_pkg::addr_width-1:0]     exp_addr  [num_tags];
    logic [cache_pkg::core_tag_width-1:0] order_tag [num_tags];
    int    ord_wr = 0;
    int    ord_rd = 0;
    int    err_main = 0;
    int    err_cmp = 0;
    int    checks = 0;
    int    cycle = 0;
    int    err_start;
    int    mem_start;
    int    taken_in_test;
    int    stall_at;
    int    mem_delay_fixed = 0;
    int    mem_req_cnt = 0;
    int    delay;
    bit    in_order = 0;
    bit    expect_hit = 0;
    bit    stall_seen;
    string test_name = "reset";
    logic [cache_pkg::core_tag_width-1:0]  next_tag;
    logic [cache_pkg::core_tag_width-1:0]  rsp_idx;
    logic [cache_pkg::line_addr_width-1:0] last_req_addr = '0;
    logic [cache_pkg::line_addr_width-1:0] mem_q_addr [$];
    int                                    mem_q_due [$];

    cache_bank #(.mrvq_size(mrvq_size), .num_sets(num_sets)) uut (.*);

    always #10 clk = ~clk;

    always @(posedge clk) cycle <= cycle + 1;

    function automatic logic [cache_pkg::word_width-1:0] expected_word(
        input logic [cache_pkg::addr_width-1:0] addr
    );
        return (32'(addr) * 32'h9e37_79b9) ^ 32'h5a3c_96e1;
    endfunction

    function automatic cache_pkg::line_t make_line(
        input logic [cache_pkg::line_addr_width-1:0] line_addr
    );
        cache_pkg::line_t line;
        for (int w = 0; w < cache_pkg::words_per_line; w++) begin
            line[w*cache_pkg::word_width +: cache_pkg::word_width] =
                expected_word({line_addr, cache_pkg::wsel_width'(w)});
        end
        return line;
    endfunction

    // Memory returns lines in request order, at most one per cycle
    always @(posedge clk) begin
        #1;
        if (mem_req_valid) begin
            delay = (mem_delay_fixed > 0) ? mem_delay_fixed : 3 + int'($urandom % 18);
            mem_q_addr.push_back(mem_req_addr);
            mem_q_due.push_back(cycle + delay);
            mem_req_cnt = mem_req_cnt + 1;
            last_req_addr = mem_req_addr;
        end
        if (mem_q_due.size() > 0 && mem_q_due[0] <= cycle) begin
            mem_rsp_valid = 1'b1;
            mem_rsp_addr  = mem_q_addr.pop_front();
            mem_rsp_data  = make_line(mem_rsp_addr);
            void'(mem_q_due.pop_front());
        end else begin
            mem_rsp_valid = 1'b0;
        end
    end

    task automatic check_word(input string name, input logic [cache_pkg::word_width-1:0] expected,
                              input logic [cache_pkg::word_width-1:0] actual);
        checks = checks + 1;
        if (actual !== expected) begin
            err_cmp = err_cmp + 1;
            $display("MISMATCH %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic check_tag(input string name, input logic [cache_pkg::core_tag_width-1:0] expected,
                             input logic [cache_pkg::core_tag_width-1:0] actual);
        checks = checks + 1;
        if (actual !== expected) begin
            err_cmp = err_cmp + 1;
            $display("MISMATCH %s: expected tag %0d, actual tag %0d", name, expected, actual);
        end
    endtask

    task automatic check_line_addr(input string name,
                                   input logic [cache_pkg::line_addr_width-1:0] expected,
                                   input logic [cache_pkg::line_addr_width-1:0] actual);
        checks = checks + 1;
        if (actual !== expected) begin
            err_main = err_main + 1;
            $display("MISMATCH %s: expected line %h, actual line %h", name, expected, actual);
        end
    endtask

    always @(negedge clk) begin
        if (!reset && core_rsp_valid) begin
            rsp_idx = core_rsp_tag;
            if (issue_cnt[rsp_idx] == done_cnt[rsp_idx]) begin
                err_cmp = err_cmp + 1;
                $display("%s: response with tag %0d that is not outstanding", test_name, rsp_idx);
            end else begin
                check_word(test_name, expected_word(exp_addr[rsp_idx]), core_rsp_data);
                if (in_order) begin
                    check_tag(test_name, order_tag[ord_rd], core_rsp_tag);
                    ord_rd = ord_rd + 1;
                end
                if (expect_hit && cycle - take_cycle[rsp_idx] != 1) begin
                    err_cmp = err_cmp + 1;
                    $display("MISMATCH %s: hit latency expected 1, actual %0d",
                             test_name, cycle - take_cycle[rsp_idx]);
                end
                done_cnt[rsp_idx] = done_cnt[rsp_idx] + 1;
            end
        end
    end

    task automatic abort_on_timeout(input string what);
        $display("%s: timed out while %s", test_name, what);
        $display("TEST FAILED");
        $finish;
    endtask

    function automatic bit busy();
        for (int t = 0; t < num_tags; t++) begin
            if (issue_cnt[t] != done_cnt[t]) return 1'b1;
        end
        return mem_q_due.size() > 0;
    endfunction

    // Holds the request until the bank takes it
    task automatic read_word(input logic [cache_pkg::addr_width-1:0] addr,
                             input logic [cache_pkg::core_tag_width-1:0] tag);
        int waited;
        waited = 0;
        core_req_valid = 1'b1;
        core_req_addr  = addr;
        core_req_tag   = tag;
        @(negedge clk);
        while (core_req_stall) begin
            if (!stall_seen) stall_at = taken_in_test;
            stall_seen = 1'b1;
            if (waited >= wait_limit) abort_on_timeout("a request stayed stalled");
            waited = waited + 1;
            @(negedge clk);
        end
        take_cycle[tag] = cycle;
        exp_addr[tag]   = addr;
        issue_cnt[tag]  = issue_cnt[tag] + 1;
        if (in_order) begin
            order_tag[ord_wr] = tag;
            ord_wr = ord_wr + 1;
        end
        taken_in_test = taken_in_test + 1;
        @(posedge clk);
        #1;
        core_req_valid = 1'b0;
    endtask

    task automatic wait_idle();
        int waited;
        waited = 0;
        while (busy()) begin
            if (waited >= wait_limit) abort_on_timeout("waiting for responses and fills");
            waited = waited + 1;
            @(posedge clk);
            #1;
        end
    endtask

    task automatic wait_tag_free(input logic [cache_pkg::core_tag_width-1:0] tag);
        int waited;
        waited = 0;
        while (issue_cnt[tag] != done_cnt[tag]) begin
            if (waited >= wait_limit) abort_on_timeout("waiting for a tag to come back");
            waited = waited + 1;
            @(posedge clk);
            #1;
        end
    endtask

    task automatic start_test(input string name);
        test_name     = name;
        err_start     = err_main + err_cmp;
        mem_start     = mem_req_cnt;
        taken_in_test = 0;
        stall_seen    = 1'b0;
    endtask

    task automatic expect_count(input string what, input int expected, input int actual);
        if (actual != expected) begin
            err_main = err_main + 1;
            $display("MISMATCH %s: %s expected %0d, actual %0d",
                     test_name, what, expected, actual);
        end
    endtask

    task automatic end_test();
        $display("%s: finished with %0d errors", test_name, err_main + err_cmp - err_start);
    endtask

    initial begin
        void'($urandom(32'h770f));
        repeat (3) @(posedge clk);
        #1;
        reset = 1'b0;

        start_test("test1 first miss");
        @(negedge clk);
        if (core_rsp_valid !== 1'b0 || mem_req_valid !== 1'b0 || core_req_stall !== 1'b0) begin
            err_main = err_main + 1;
            $display("%s: response, memory request or stall not low after reset", test_name);
        end
        @(posedge clk);
        #1;
        read_word(16'h0012, 6'd1);
        wait_idle();
        expect_count("number of memory requests", 1, mem_req_cnt - mem_start);
        check_line_addr(test_name,
                        cache_pkg::line_addr_width'(16'h0012 >> cache_pkg::wsel_width),
                        last_req_addr);
        end_test();

        start_test("test2 repeated hit");
        expect_hit = 1'b1;
        read_word(16'h0012, 6'd2);
        wait_idle();
        expect_hit = 1'b0;
        expect_count("number of memory requests", 0, mem_req_cnt - mem_start);
        end_test();

        start_test("test3 same line misses");
        in_order = 1'b1;
        for (int i = 0; i < 4; i++) read_word(16'h0100 + 16'(i), 6'(3 + i));
        wait_idle();
        in_order = 1'b0;
        expect_count("number of memory requests", 1, mem_req_cnt - mem_start);
        end_test();

        start_test("test4 queue stall");
        mem_delay_fixed = 300;
        in_order = 1'b1;
        for (int i = 0; i < 10; i++) read_word(16'h1000 + 16'(4 * i), 6'(10 + i));
        wait_idle();
        in_order = 1'b0;
        mem_delay_fixed = 0;
        expect_count("requests taken before the first stall", mrvq_size - 1,
                     stall_seen ? stall_at : -1);
        end_test();

        start_test("test5 set conflict");
        for (int i = 0; i < 3; i++) begin
            read_word(16'h2000 + 16'(i), 6'(20 + 2 * i));
            read_word(16'h2040 + 16'(i), 6'(21 + 2 * i));
        end
        wait_idle();
        end_test();

        start_test("test6 random reads");
        next_tag = '0;
        for (int i = 0; i < 400; i++) begin
            wait_tag_free(next_tag);
            read_word(16'($urandom % 128), next_tag);
            next_tag = next_tag + 1'b1;
        end
        wait_idle();
        end_test();

        $display("tests 6, checks %0d, errors %0d", checks, err_main + err_cmp);
        if (err_main + err_cmp == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* flist.f */
cache_pkg.sv
miss_if.sv
cache_miss_resrv.sv
cache_tag_data.sv
cache_bank_ctrl.sv
cache_bank.sv
cache_bank_checker.sv
cache_bank_tb.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f flist.f --top-module cache_bank_tb -o sim_cache_bank
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_cache_bank > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -q "TEST FAILED" sim.log; then
    exit 1
fi
exit 0
